/* src/cntmem_defines.svh */
`ifndef CNTMEM_DEFINES_SVH
`define CNTMEM_DEFINES_SVH

// Counter array geometry.
`define CNT_WIDTH 16
`define CNT_DEPTH 64
`define NUM_BANK  4
`define INC_WIDTH 8

// APB bus widths.
`define APB_ADDR_WIDTH 12
`define APB_DATA_WIDTH 32

// Register map in byte offsets.
`define REG_ERR_STATUS 12'h000
`define REG_ERR_COUNT  12'h004
`define REG_INJECT     12'h008
`define CNT_WINDOW     12'h100  // One word per counter.

`endif

/* src/cntmem_addr_pkg.sv */
`default_nettype none
`include "cntmem_defines.svh"

package cntmem_addr_pkg;

  localparam int ADDR_BITS = $clog2(`CNT_DEPTH);
  localparam int BANK_BITS = $clog2(`NUM_BANK);
  localparam int ROW_BITS  = ADDR_BITS - BANK_BITS;

  typedef logic [ADDR_BITS-1:0] cnt_addr_t;  // Logical counter index.
  typedef logic [BANK_BITS-1:0] bank_sel_t;
  typedef logic [ROW_BITS-1:0]  row_t;

  // Interleaved split so that neighbouring counters sit in different banks.
  typedef struct packed {
    row_t      row;
    bank_sel_t bank;
  } row_bank_t;

  // One physical address word, read flat or as row and bank.
  typedef union packed {
    cnt_addr_t flat;  // Reported in the error status.
    row_bank_t rb;    // Decoded by the bank array.
  } phys_addr_u;

endpackage

`default_nettype wire

/* src/cntmem_err_pkg.sv */
`default_nettype none
`include "cntmem_defines.svh"

package cntmem_err_pkg;

  typedef logic [`CNT_WIDTH-1:0] cnt_word_t;

  // First recorded parity error.
  typedef struct packed {
    logic                        seen;
    cntmem_addr_pkg::phys_addr_u addr;
  } err_status_t;

  // Owner of a memory port.
  typedef enum logic {
    UPD  = 1'b0,
    HOST = 1'b1
  } req_src_e;

endpackage

`default_nettype wire

/* src/cntmem_bank_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cntmem_defines.svh"

module cntmem_bank_array (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             rd_en,
  input  wire cntmem_addr_pkg::cnt_addr_t rd_addr,
  output cntmem_err_pkg::cnt_word_t       rd_data,
  output logic                            rd_perr,
  input  wire                             wr_en,
  input  wire cntmem_addr_pkg::cnt_addr_t wr_addr,
  input  wire cntmem_err_pkg::cnt_word_t  wr_data,
  input  wire                             wr_inject
);
  import cntmem_addr_pkg::*;

  localparam int ROWS = `CNT_DEPTH / `NUM_BANK;

  phys_addr_u          rd_pa;
  phys_addr_u          wr_pa;
  logic                wr_par;
  bank_sel_t           rd_bank_q;
  logic                rd_vld_q;
  logic [`CNT_WIDTH:0] bank_q [`NUM_BANK];  // Parity bit on top.

  assign rd_pa.flat = rd_addr;
  assign wr_pa.flat = wr_addr;
  assign wr_par     = (^wr_data) ^ wr_inject;  // Even parity, flipped on injection.

  // ------------------------------------------------------------
  // One 1R1W bank per low address pair value.
  for (genvar b = 0; b < `NUM_BANK; b++) begin : g_bank
    logic [`CNT_WIDTH:0] mem [ROWS];
    logic [`CNT_WIDTH:0] q;

    always_ff @(posedge clk) begin
      if (wr_en && (wr_pa.rb.bank == bank_sel_t'(b))) begin
        mem[wr_pa.rb.row] <= {wr_par, wr_data};
      end
      if (rd_en && (rd_pa.rb.bank == bank_sel_t'(b))) begin
        q <= mem[rd_pa.rb.row];
      end
    end

    assign bank_q[b] = q;
  end

  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_bank_q <= rd_pa.rb.bank;  // Selects the returning bank.
    end
  end

  assign rd_data = bank_q[rd_bank_q][`CNT_WIDTH-1:0];
  assign rd_perr = rd_vld_q && (^bank_q[rd_bank_q]);

endmodule

`default_nettype wire

/* src/cntmem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cntmem_arbiter (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             upd_rd_req,
  input  wire cntmem_addr_pkg::cnt_addr_t upd_rd_addr,
  input  wire                             upd_wr_req,
  input  wire cntmem_addr_pkg::cnt_addr_t upd_wr_addr,
  input  wire cntmem_err_pkg::cnt_word_t  upd_wr_data,
  input  wire                             host_rd_req,
  input  wire cntmem_addr_pkg::cnt_addr_t host_rd_addr,
  input  wire                             host_wr_req,
  input  wire cntmem_addr_pkg::cnt_addr_t host_wr_addr,
  input  wire cntmem_err_pkg::cnt_word_t  host_wr_data,
  output logic                            host_rd_gnt,
  output logic                            host_wr_gnt,
  output logic                            rd_en,
  output cntmem_addr_pkg::cnt_addr_t      rd_addr,
  output logic                            wr_en,
  output cntmem_addr_pkg::cnt_addr_t      wr_addr,
  output cntmem_err_pkg::cnt_word_t       wr_data,
  output cntmem_err_pkg::req_src_e        rd_src
);
  import cntmem_err_pkg::*;

  // Host waits while the engine owns the port.
  // It also waits while the engine is mid-update on the same counter.
  assign host_rd_gnt = host_rd_req && !upd_rd_req &&
                       !(upd_wr_req && (upd_wr_addr == host_rd_addr));
  assign host_wr_gnt = host_wr_req && !upd_wr_req &&
                       !(upd_rd_req && (upd_rd_addr == host_wr_addr));

  assign rd_en   = upd_rd_req || host_rd_gnt;
  assign rd_addr = upd_rd_req ? upd_rd_addr : host_rd_addr;

  assign wr_en   = upd_wr_req || host_wr_gnt;
  assign wr_addr = upd_wr_req ? upd_wr_addr : host_wr_addr;
  assign wr_data = upd_wr_req ? upd_wr_data : host_wr_data;

  // Owner of the read whose data returns next cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_src <= UPD;
    end else if (rd_en) begin
      rd_src <= upd_rd_req ? UPD : HOST;
    end
  end

endmodule

`default_nettype wire

/* src/cntmem_update_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cntmem_defines.svh"

module cntmem_update_engine (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             upd_valid,
  input  wire cntmem_addr_pkg::cnt_addr_t upd_addr,
  input  wire [`INC_WIDTH-1:0]            upd_inc,
  output logic                            rd_req,
  output cntmem_addr_pkg::cnt_addr_t      rd_addr,
  input  wire cntmem_err_pkg::cnt_word_t  rd_data,
  input  wire                             rd_perr,
  input  wire cntmem_err_pkg::req_src_e   rd_src,
  output logic                            wr_req,
  output cntmem_addr_pkg::cnt_addr_t      wr_addr,
  output cntmem_err_pkg::cnt_word_t       wr_data,
  output logic                            err_valid,
  output cntmem_addr_pkg::phys_addr_u     err_addr
);
  import cntmem_addr_pkg::*;
  import cntmem_err_pkg::*;

  // Stage 1 holds the request whose read data is returning.
  logic                  s1_valid;
  cnt_addr_t             s1_addr;
  logic [`INC_WIDTH-1:0] s1_inc;
  // Stage 2 holds the sum written on the previous cycle.
  logic                  s2_valid;
  cnt_addr_t             s2_addr;
  cnt_word_t             s2_sum;

  logic                  fwd;
  cnt_word_t             operand;
  logic [`CNT_WIDTH:0]   sum_ext;
  cnt_word_t             sum_sat;

  assign rd_req  = upd_valid;  // Read goes out in the accept cycle.
  assign rd_addr = upd_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= upd_valid;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_addr <= upd_addr;
    s1_inc  <= upd_inc;
    s2_addr <= s1_addr;
    s2_sum  <= sum_sat;
  end

  // ------------------------------------------------------------
  // Bank data is stale when the previous sum targets the same counter.
  assign fwd     = s2_valid && (s2_addr == s1_addr);
  assign operand = fwd ? s2_sum : rd_data;
  assign sum_ext = {1'b0, operand} + {{(`CNT_WIDTH - `INC_WIDTH + 1){1'b0}}, s1_inc};
  assign sum_sat = sum_ext[`CNT_WIDTH] ? '1 : sum_ext[`CNT_WIDTH-1:0];  // Clamp.

  assign wr_req  = s1_valid;
  assign wr_addr = s1_addr;
  assign wr_data = sum_sat;  // Fresh parity rewrites a bad word.

  assign err_valid     = s1_valid && rd_perr && (rd_src == UPD);
  assign err_addr.flat = s1_addr;

endmodule

`default_nettype wire

/* src/cntmem_apb_host.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cntmem_defines.svh"

module cntmem_apb_host (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              psel,
  input  wire                              penable,
  input  wire                              pwrite,
  input  wire [`APB_ADDR_WIDTH-1:0]        paddr,
  input  wire [`APB_DATA_WIDTH-1:0]        pwdata,
  output logic [`APB_DATA_WIDTH-1:0]       prdata,
  output logic                             pready,
  output logic                             pslverr,
  output logic                             rd_req,
  output cntmem_addr_pkg::cnt_addr_t       rd_addr,
  input  wire                              rd_gnt,
  input  wire cntmem_err_pkg::cnt_word_t   rd_data,
  input  wire                              rd_perr,
  input  wire cntmem_err_pkg::req_src_e    rd_src,
  output logic                             wr_req,
  output cntmem_addr_pkg::cnt_addr_t       wr_addr,
  output cntmem_err_pkg::cnt_word_t        wr_data,
  input  wire                              wr_gnt,
  output logic                             inject,
  input  wire                              upd_err_valid,
  input  wire cntmem_addr_pkg::phys_addr_u upd_err_addr
);
  import cntmem_addr_pkg::*;
  import cntmem_err_pkg::*;

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_RD_REQ  = 2'd1;
  localparam logic [1:0] ST_RD_DATA = 2'd2;
  localparam logic [1:0] ST_WR_REQ  = 2'd3;

  logic [1:0]                 state_q;
  logic                       access;
  logic                       win_hit;
  logic                       reg_hit;
  logic                       reg_acc;
  logic                       reg_wr;
  logic [`APB_ADDR_WIDTH-1:0] win_off;
  phys_addr_u                 host_pa;
  logic                       own_err;
  logic                       any_err;
  phys_addr_u                 new_err_addr;
  err_status_t                err_status_q;
  logic [`CNT_WIDTH-1:0]      err_count_q;
  logic                       inject_armed;
  logic [`APB_DATA_WIDTH-1:0] reg_rdata;

  assign access  = psel && penable;
  assign win_off = paddr - `CNT_WINDOW;
  assign win_hit = (paddr >= `CNT_WINDOW) && (win_off < `APB_ADDR_WIDTH'(4 * `CNT_DEPTH));
  assign reg_hit = (paddr == `REG_ERR_STATUS) || (paddr == `REG_ERR_COUNT) ||
                   (paddr == `REG_INJECT);
  assign reg_acc = (state_q == ST_IDLE) && access && !win_hit;  // Done in one cycle.
  assign reg_wr  = reg_acc && pwrite && reg_hit;
  assign host_pa.flat = win_off[2 +: ADDR_BITS];

  // ------------------------------------------------------------
  // Counter window FSM. paddr and pwdata stay stable until pready.
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (access && win_hit) begin
            state_q <= pwrite ? ST_WR_REQ : ST_RD_REQ;
          end
        end
        ST_RD_REQ: begin
          if (rd_gnt) begin
            state_q <= ST_RD_DATA;
          end
        end
        ST_RD_DATA: state_q <= ST_IDLE;
        default: begin
          if (wr_gnt) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  assign rd_req  = (state_q == ST_RD_REQ);
  assign rd_addr = host_pa.flat;
  assign wr_req  = (state_q == ST_WR_REQ);
  assign wr_addr = host_pa.flat;
  assign wr_data = pwdata[`CNT_WIDTH-1:0];
  assign inject  = inject_armed && wr_gnt;  // Only the granted host write.

  assign pready  = reg_acc || (state_q == ST_RD_DATA) || ((state_q == ST_WR_REQ) && wr_gnt);
  assign pslverr = reg_acc && !reg_hit;

  // ------------------------------------------------------------
  // Error status keeps the first error. Bit 0 is the flag, bits 8 up the address.
  always_comb begin
    reg_rdata = '0;
    case (paddr)
      `REG_ERR_STATUS: begin
        reg_rdata[0]              = err_status_q.seen;
        reg_rdata[8 +: ADDR_BITS] = err_status_q.addr.flat;
      end
      `REG_ERR_COUNT: reg_rdata[`CNT_WIDTH-1:0] = err_count_q;
      `REG_INJECT:    reg_rdata[0] = inject_armed;
      default:        reg_rdata = '0;
    endcase
  end

  assign prdata = (state_q == ST_RD_DATA) ? `APB_DATA_WIDTH'(rd_data) : reg_rdata;

  assign own_err      = (state_q == ST_RD_DATA) && rd_perr && (rd_src == HOST);
  assign any_err      = own_err || upd_err_valid;
  assign new_err_addr = own_err ? host_pa : upd_err_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      err_status_q <= '0;
      err_count_q  <= '0;
      inject_armed <= 1'b0;
    end else begin
      if (any_err && (!err_status_q.seen || (reg_wr && paddr == `REG_ERR_STATUS))) begin
        err_status_q.seen <= 1'b1;
        err_status_q.addr <= new_err_addr;
      end else if (reg_wr && (paddr == `REG_ERR_STATUS)) begin
        err_status_q <= '0;  // Write clears.
      end
      if (reg_wr && (paddr == `REG_ERR_COUNT)) begin
        err_count_q <= '0;
      end else if (any_err) begin
        err_count_q <= err_count_q + 1'b1;
      end
      if (wr_gnt) begin
        inject_armed <= 1'b0;
      end else if (reg_wr && (paddr == `REG_INJECT)) begin
        inject_armed <= pwdata[0];
      end
    end
  end

endmodule

`default_nettype wire

/* src/cntmem_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cntmem_defines.svh"

module cntmem_top (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             upd_valid,
  input  wire cntmem_addr_pkg::cnt_addr_t upd_addr,
  input  wire [`INC_WIDTH-1:0]            upd_inc,
  input  wire                             psel,
  input  wire                             penable,
  input  wire                             pwrite,
  input  wire [`APB_ADDR_WIDTH-1:0]       paddr,
  input  wire [`APB_DATA_WIDTH-1:0]       pwdata,
  output logic [`APB_DATA_WIDTH-1:0]      prdata,
  output logic                            pready,
  output logic                            pslverr
);
  import cntmem_addr_pkg::*;
  import cntmem_err_pkg::*;

  logic       upd_rd_req;
  cnt_addr_t  upd_rd_addr;
  logic       upd_wr_req;
  cnt_addr_t  upd_wr_addr;
  cnt_word_t  upd_wr_data;
  logic       upd_err_valid;
  phys_addr_u upd_err_addr;
  logic       host_rd_req;
  cnt_addr_t  host_rd_addr;
  logic       host_rd_gnt;
  logic       host_wr_req;
  cnt_addr_t  host_wr_addr;
  cnt_word_t  host_wr_data;
  logic       host_wr_gnt;
  logic       inject;
  logic       rd_en;
  cnt_addr_t  rd_addr;
  cnt_word_t  rd_data;
  logic       rd_perr;
  req_src_e   rd_src;
  logic       wr_en;
  cnt_addr_t  wr_addr;
  cnt_word_t  wr_data;

  cntmem_bank_array u_bank_array (
    .clk, .rst, .rd_en, .rd_addr, .rd_data, .rd_perr,
    .wr_en, .wr_addr, .wr_data, .wr_inject (inject)
  );

  cntmem_arbiter u_arbiter (
    .clk, .rst,
    .upd_rd_req, .upd_rd_addr, .upd_wr_req, .upd_wr_addr, .upd_wr_data,
    .host_rd_req, .host_rd_addr, .host_wr_req, .host_wr_addr, .host_wr_data,
    .host_rd_gnt, .host_wr_gnt,
    .rd_en, .rd_addr, .wr_en, .wr_addr, .wr_data, .rd_src
  );

  cntmem_update_engine u_update_engine (
    .clk, .rst, .upd_valid, .upd_addr, .upd_inc,
    .rd_req (upd_rd_req), .rd_addr (upd_rd_addr), .rd_data, .rd_perr, .rd_src,
    .wr_req (upd_wr_req), .wr_addr (upd_wr_addr), .wr_data (upd_wr_data),
    .err_valid (upd_err_valid), .err_addr (upd_err_addr)
  );

  cntmem_apb_host u_apb_host (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .rd_req (host_rd_req), .rd_addr (host_rd_addr), .rd_gnt (host_rd_gnt),
    .rd_data, .rd_perr, .rd_src,
    .wr_req (host_wr_req), .wr_addr (host_wr_addr), .wr_data (host_wr_data),
    .wr_gnt (host_wr_gnt), .inject, .upd_err_valid, .upd_err_addr
  );

endmodule

`default_nettype wire

/* sim/cntmem_shadow.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cntmem_defines.svh"

module cntmem_shadow (
  input wire                             clk,
  input wire                             rst,
  input wire                             upd_valid,
  input wire cntmem_addr_pkg::cnt_addr_t upd_addr,
  input wire [`INC_WIDTH-1:0]            upd_inc,
  input wire                             psel,
  input wire                             penable,
  input wire                             pwrite,
  input wire [`APB_ADDR_WIDTH-1:0]       paddr,
  input wire [`APB_DATA_WIDTH-1:0]       pwdata,
  input wire                             pready
);
  localparam int ADDR_BITS = $clog2(`CNT_DEPTH);
  localparam int CNT_MAX   = (1 << `CNT_WIDTH) - 1;

  logic [`CNT_WIDTH-1:0]      cnt_q [`CNT_DEPTH];  // Expected counter values.
  logic [`APB_ADDR_WIDTH-1:0] win_off;
  logic                       host_wr;

  // Counter plus increment, clamped at the counter maximum.
  function automatic logic [`CNT_WIDTH-1:0] sat_add(input logic [`CNT_WIDTH-1:0] cur,
                                                     input logic [`INC_WIDTH-1:0] inc);
    int total;
    total = int'(cur) + int'(inc);
    if (total > CNT_MAX) begin
      total = CNT_MAX;
    end
    return total[`CNT_WIDTH-1:0];
  endfunction

  // A completed APB write that lands in the counter window.
  assign win_off = paddr - `CNT_WINDOW;
  assign host_wr = psel && penable && pwrite && pready && (paddr >= `CNT_WINDOW) &&
                   (win_off < `APB_ADDR_WIDTH'(4 * `CNT_DEPTH));

  always @(posedge clk) begin
    if (!rst) begin
      if (upd_valid) begin
        cnt_q[upd_addr] <= sat_add(cnt_q[upd_addr], upd_inc);
      end
      if (host_wr) begin
        cnt_q[win_off[2 +: ADDR_BITS]] <= pwdata[`CNT_WIDTH-1:0];  // Host overwrite.
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_cntmem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cntmem_defines.svh"

module tb_cntmem;
  import cntmem_addr_pkg::*;

  localparam int        MAX_CYCLES = 4000;  // About three times the full test sequence.
  localparam cnt_addr_t SAT_A      = 6'd3;
  localparam cnt_addr_t SAT_B      = 6'd41;
  localparam cnt_addr_t FWD_A      = 6'd10;
  localparam cnt_addr_t FWD_B      = 6'd14;  // Same bank as FWD_A.
  localparam cnt_addr_t BURST_TGT  = 6'd33;
  localparam cnt_addr_t INJ_A      = 6'd22;
  localparam cnt_addr_t INJ_B      = 6'd57;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       upd_valid;
  cnt_addr_t                  upd_addr;
  logic [`INC_WIDTH-1:0]      upd_inc;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`APB_ADDR_WIDTH-1:0] paddr;
  logic [`APB_DATA_WIDTH-1:0] pwdata;
  logic [`APB_DATA_WIDTH-1:0] prdata;
  logic                       pready;
  logic                       pslverr;
  int                         cycle_cnt = 0;
  int                         err_cnt = 0;
  int                         test_cnt = 0;

  cntmem_top UUT (
    .clk, .rst, .upd_valid, .upd_addr, .upd_inc,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  cntmem_shadow shadow (
    .clk, .rst, .upd_valid, .upd_addr, .upd_inc,
    .psel, .penable, .pwrite, .paddr, .pwdata, .pready
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: tests still running after %0d clock cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  task automatic flag_mismatch(input string msg, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("FAIL at %0t: %s, got 0x%0h, expected 0x%0h", $time, msg, got, exp);
    err_cnt++;
  endtask

  task automatic note_failure(input string msg);
    $display("Error: %s", msg);
    err_cnt++;
  endtask

  function automatic logic [11:0] win_addr(input int idx);
    return 12'(`CNT_WINDOW + 4 * idx);
  endfunction

  function automatic logic [15:0] fill_value(input int idx);
    return 16'(idx * 16'h0405 + 16'h13c1);
  endfunction

  // One beat on the update port, held until the next rising edge.
  task automatic upd_beat(input logic valid, input cnt_addr_t addr, input logic [7:0] inc);
    @(posedge clk);
    upd_valid <= valid;
    upd_addr  <= addr;
    upd_inc   <= inc;
  endtask

  task automatic wait_ready();
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    wait_ready();
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    wait_ready();
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // ------------------------------------------------------------
  task automatic test_write_readback();
    logic [31:0] rd;
    logic        err;
    test_cnt++;
    for (int i = 0; i < `CNT_DEPTH; i++) begin
      apb_write(win_addr(i), {16'h0, fill_value(i)}, err);
      if (err) begin
        flag_mismatch($sformatf("pslverr on write of counter %0d", i), 32'(err), 32'h0);
      end
    end
    for (int i = 0; i < `CNT_DEPTH; i++) begin
      apb_read(win_addr(i), rd, err);
      if (rd != {16'h0, fill_value(i)}) begin
        flag_mismatch($sformatf("readback of counter %0d", i), rd, {16'h0, fill_value(i)});
      end
    end
  endtask

  task automatic test_random_updates();
    cnt_addr_t   a;
    logic [7:0]  inc;
    logic [31:0] rd;
    logic        err;
    test_cnt++;
    apb_write(win_addr(SAT_A), 32'h0000_ffc0, err);  // Close to the maximum.
    apb_write(win_addr(SAT_B), 32'h0000_ff80, err);
    for (int n = 0; n < 40; n++) begin
      if (n % 4 == 0) begin
        a   = (n % 8 == 0) ? SAT_A : SAT_B;
        inc = 8'hff;
      end else begin
        a   = cnt_addr_t'($urandom % `CNT_DEPTH);
        inc = 8'($urandom);
      end
      upd_beat(1'b1, a, inc);
      repeat (1 + $urandom % 3) upd_beat(1'b0, '0, '0);
    end
    upd_beat(1'b0, '0, '0);
    for (int i = 0; i < `CNT_DEPTH; i++) begin
      apb_read(win_addr(i), rd, err);
      if (rd != {16'h0, shadow.cnt_q[i]}) begin
        flag_mismatch($sformatf("counter %0d after updates", i), rd, {16'h0, shadow.cnt_q[i]});
      end
    end
    apb_read(win_addr(SAT_A), rd, err);
    if (rd != 32'h0000_ffff) begin
      flag_mismatch("saturated counter", rd, 32'h0000_ffff);
    end
  endtask

  task automatic test_forwarding();
    logic [15:0] exp_a;
    logic [15:0] exp_b;
    logic [7:0]  inc;
    logic [31:0] rd;
    logic        err;
    test_cnt++;
    apb_write(win_addr(FWD_A), 32'd100, err);
    apb_write(win_addr(FWD_B), 32'd200, err);
    exp_a = 16'd100;
    exp_b = 16'd200;
    for (int n = 0; n < 6; n++) begin  // Same counter every cycle.
      inc   = 8'($urandom);
      exp_a = exp_a + {8'h0, inc};
      upd_beat(1'b1, FWD_A, inc);
    end
    for (int n = 0; n < 8; n++) begin
      inc = 8'($urandom);
      if (n % 2 == 0) begin
        exp_b = exp_b + {8'h0, inc};
        upd_beat(1'b1, FWD_B, inc);
      end else begin
        exp_a = exp_a + {8'h0, inc};
        upd_beat(1'b1, FWD_A, inc);
      end
    end
    upd_beat(1'b0, '0, '0);
    upd_beat(1'b0, '0, '0);
    apb_read(win_addr(FWD_A), rd, err);
    if (rd != {16'h0, exp_a}) begin
      flag_mismatch("forwarded sum of first counter", rd, {16'h0, exp_a});
    end
    apb_read(win_addr(FWD_B), rd, err);
    if (rd != {16'h0, exp_b}) begin
      flag_mismatch("forwarded sum of second counter", rd, {16'h0, exp_b});
    end
  endtask

  task automatic test_read_during_burst();
    logic [31:0] rd;
    logic        err;
    int          burst_end;
    int          read_done;
    test_cnt++;
    fork
      begin
        for (int n = 0; n < 16; n++) begin
          upd_beat(1'b1, (n % 3 == 0) ? BURST_TGT : cnt_addr_t'($urandom % `CNT_DEPTH),
                   8'($urandom));
        end
        burst_end = cycle_cnt;
        upd_beat(1'b0, '0, '0);
        upd_beat(1'b0, '0, '0);
      end
      begin
        repeat (2) @(posedge clk);
        apb_read(win_addr(BURST_TGT), rd, err);
        read_done = cycle_cnt;
      end
    join
    if (read_done <= burst_end) begin
      note_failure("host read completed while the update burst still held the read port");
    end
    if (rd != {16'h0, shadow.cnt_q[BURST_TGT]}) begin
      flag_mismatch("host read after burst", rd, {16'h0, shadow.cnt_q[BURST_TGT]});
    end
  endtask

  task automatic test_unmapped_access();
    logic [31:0] rd;
    logic        err;
    test_cnt++;
    apb_read(12'h00c, rd, err);
    if (err !== 1'b1) begin
      flag_mismatch("pslverr on unmapped read", 32'(err), 32'h1);
    end
    apb_write(12'h200, 32'h1234, err);  // Just past the window.
    if (err !== 1'b1) begin
      flag_mismatch("pslverr on unmapped write", 32'(err), 32'h1);
    end
    apb_read(`REG_ERR_COUNT, rd, err);
    if (err !== 1'b0) begin
      flag_mismatch("pslverr on mapped register", 32'(err), 32'h0);
    end
  endtask

  task automatic test_parity_inject();
    logic [31:0] rd;
    logic        err;
    test_cnt++;
    apb_write(`REG_ERR_STATUS, 32'h0, err);
    apb_write(`REG_ERR_COUNT, 32'h0, err);
    apb_write(`REG_INJECT, 32'h1, err);
    apb_write(win_addr(INJ_A), 32'h0000_5a5a, err);
    apb_read(win_addr(INJ_A), rd, err);
    if (rd != 32'h0000_5a5a) begin
      flag_mismatch("data of corrupted word", rd, 32'h0000_5a5a);
    end
    apb_read(`REG_ERR_STATUS, rd, err);
    if (rd != {18'h0, INJ_A, 7'h0, 1'b1}) begin
      flag_mismatch("error status after first error", rd, {18'h0, INJ_A, 7'h0, 1'b1});
    end
    apb_read(`REG_ERR_COUNT, rd, err);
    if (rd != 32'd1) begin
      flag_mismatch("error count after first error", rd, 32'd1);
    end
    // A second error must not move the recorded address.
    apb_write(`REG_INJECT, 32'h1, err);
    apb_write(win_addr(INJ_B), 32'h0000_0f0f, err);
    apb_read(win_addr(INJ_B), rd, err);
    apb_read(`REG_ERR_STATUS, rd, err);
    if (rd != {18'h0, INJ_A, 7'h0, 1'b1}) begin
      flag_mismatch("error status after second error", rd, {18'h0, INJ_A, 7'h0, 1'b1});
    end
    apb_read(`REG_ERR_COUNT, rd, err);
    if (rd != 32'd2) begin
      flag_mismatch("error count after second error", rd, 32'd2);
    end
  endtask

  // ------------------------------------------------------------
  initial begin
    void'($urandom(62));
    rst       <= 1'b1;
    upd_valid <= 1'b0;
    upd_addr  <= '0;
    upd_inc   <= '0;
    psel      <= 1'b0;
    penable   <= 1'b0;
    pwrite    <= 1'b0;
    paddr     <= '0;
    pwdata    <= '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    test_write_readback();
    test_random_updates();
    test_forwarding();
    test_read_during_burst();
    test_unmapped_access();
    test_parity_inject();
    repeat (4) @(posedge clk);
    $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/cntmem_addr_pkg.sv
src/cntmem_err_pkg.sv
src/cntmem_bank_array.sv
src/cntmem_arbiter.sv
src/cntmem_update_engine.sv
src/cntmem_apb_host.sv
src/cntmem_top.sv
sim/cntmem_shadow.sv
sim/tb_cntmem.sv

/* Makefile */
TOP = tb_cntmem

.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
